/* common/vga_config.svh */
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// Frame buffer geometry

// Visible pixels per row
`define VGA_WIDTH  160

// Visible rows per frame
`define VGA_HEIGHT 120

// Bits per pixel in the frame buffer
`define COLOUR_W   3

`endif

/* common/vga_pkg.sv */
`include "vga_config.svh"

package vga_pkg;

    // Coordinate widths sized to the frame
    localparam int X_W = $clog2(`VGA_WIDTH);
    localparam int Y_W = $clog2(`VGA_HEIGHT);

    // Column index, 0 to width - 1
    typedef logic [X_W-1:0] coord_x_t;

    // Row index, 0 to height - 1
    typedef logic [Y_W-1:0] coord_y_t;

    // One frame buffer pixel
    typedef logic [`COLOUR_W-1:0] colour_t;

endpackage

/* common/fill_pkg.sv */
package fill_pkg;

    // Pattern selected by the fill command
    typedef enum logic [1:0] {
        FILL_SOLID    = 2'd0,
        FILL_COLUMNS  = 2'd1,
        FILL_ROWS     = 2'd2,
        FILL_DIAGONAL = 2'd3
    } fill_mode_e;

    // Frame walk states
    typedef enum logic [1:0] {
        SCAN_IDLE = 2'd0,
        SCAN_DRAW = 2'd1,
        SCAN_DONE = 2'd2
    } scan_state_e;

endpackage

/* hw/fill_cmd_decode.sv */
module fill_cmd_decode
    import vga_pkg::*;
    import fill_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  colour_t    colour,
    input  fill_mode_e mode,
    input  logic       scan_done,
    output colour_t    cmd_colour,
    output fill_mode_e cmd_mode,
    output logic       launch,
    output logic       busy
);

    logic start_q;
    logic scan_done_q;
    logic accept;
    logic pass_end;

    // --------------------------------------------------
    // Edge detection
    // --------------------------------------------------

    // A start held across a whole pass must not fire again
    assign accept   = start && !start_q && !busy;
    assign pass_end = scan_done && !scan_done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q     <= 1'b0;
            scan_done_q <= 1'b0;
        end else begin
            start_q     <= start;
            scan_done_q <= scan_done;
        end
    end

    // --------------------------------------------------
    // Busy flag and launch pulse
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            launch <= 1'b0;
        end else begin
            launch <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (pass_end) begin
                busy <= 1'b0;
            end
        end
    end

    // Command held for the whole pass
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_colour <= colour;
            cmd_mode   <= mode;
        end
    end

    // One pass per accepted start
    launch_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) launch |=> !launch
    );

endmodule

/* hw/fillscreen/pixel_scanner.sv */
`include "vga_config.svh"

module pixel_scanner
    import vga_pkg::*;
    import fill_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     launch,
    output coord_x_t pix_x,
    output coord_y_t pix_y,
    output logic     pix_valid,
    output logic     scan_done
);

    localparam coord_x_t X_LAST = coord_x_t'(`VGA_WIDTH - 1);
    localparam coord_y_t Y_LAST = coord_y_t'(`VGA_HEIGHT - 1);

    scan_state_e state;

    logic last_row;
    logic last_col;

    assign last_row = (pix_y == Y_LAST);
    assign last_col = (pix_x == X_LAST);

    // --------------------------------------------------
    // Walk FSM
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SCAN_IDLE;
            pix_valid <= 1'b0;
            scan_done <= 1'b0;
        end else if (launch) begin
            // Restart from the origin in any state
            state     <= SCAN_DRAW;
            pix_valid <= 1'b1;
            scan_done <= 1'b0;
        end else begin
            case (state)
                SCAN_DRAW: begin
                    if (last_row && last_col) begin
                        state     <= SCAN_DONE;
                        pix_valid <= 1'b0;
                        scan_done <= 1'b1;
                    end
                end
                SCAN_DONE: begin
                    scan_done <= 1'b1;
                end
                default: begin
                    state     <= SCAN_IDLE;
                    pix_valid <= 1'b0;
                    scan_done <= 1'b0;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Coordinate counters
    // --------------------------------------------------

    // y is the inner loop, x steps when y wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_x <= '0;
            pix_y <= '0;
        end else if (launch) begin
            pix_x <= '0;
            pix_y <= '0;
        end else if (state == SCAN_DRAW) begin
            if (last_row) begin
                pix_y <= '0;
                if (!last_col) begin
                    pix_x <= pix_x + 1'b1;
                end
            end else begin
                pix_y <= pix_y + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    x_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) pix_valid |-> (pix_x < `VGA_WIDTH)
    );

    y_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) pix_valid |-> (pix_y < `VGA_HEIGHT)
    );

    // Flags are separate flops so they could drift apart
    done_excludes_valid: assert property (
        @(posedge clk) disable iff (!rst_n) !(scan_done && pix_valid)
    );

endmodule

/* hw/pixel_colour_unit.sv */
module pixel_colour_unit
    import vga_pkg::*;
    import fill_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  coord_x_t   pix_x,
    input  coord_y_t   pix_y,
    input  logic       pix_valid,
    input  colour_t    cmd_colour,
    input  fill_mode_e cmd_mode,
    output coord_x_t   vga_x,
    output coord_y_t   vga_y,
    output colour_t    vga_colour,
    output logic       vga_plot
);

    colour_t diag_colour;
    colour_t pix_colour;

    // --------------------------------------------------
    // Pattern select
    // --------------------------------------------------

    // Low bits only, so the sum wraps mod 8 by itself
    assign diag_colour = colour_t'(pix_x) + colour_t'(pix_y);

    always_comb begin
        case (cmd_mode)
            FILL_SOLID:    pix_colour = cmd_colour;
            FILL_COLUMNS:  pix_colour = colour_t'(pix_x);
            FILL_ROWS:     pix_colour = colour_t'(pix_y);
            FILL_DIAGONAL: pix_colour = diag_colour;
            default:       pix_colour = cmd_colour;
        endcase
    end

    // --------------------------------------------------
    // VGA output registers
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_plot <= 1'b0;
        end else begin
            vga_plot <= pix_valid;
        end
    end

    // Pixel payload
    always_ff @(posedge clk) begin
        vga_x      <= pix_x;
        vga_y      <= pix_y;
        vga_colour <= pix_colour;
    end

endmodule

/* hw/fillscreen.sv */
module fillscreen
    import vga_pkg::*;
    import fill_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  colour_t    colour,
    input  fill_mode_e mode,
    output logic       done,
    output coord_x_t   vga_x,
    output coord_y_t   vga_y,
    output colour_t    vga_colour,
    output logic       vga_plot
);

    colour_t    cmd_colour;
    fill_mode_e cmd_mode;
    logic       launch;
    logic       busy;
    coord_x_t   pix_x;
    coord_y_t   pix_y;
    logic       pix_valid;
    logic       scan_done;

    fill_cmd_decode cmd_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .mode       (mode),
        .scan_done  (scan_done),
        .cmd_colour (cmd_colour),
        .cmd_mode   (cmd_mode),
        .launch     (launch),
        .busy       (busy)
    );

    pixel_scanner scan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .launch    (launch),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_valid (pix_valid),
        .scan_done (scan_done)
    );

    pixel_colour_unit colour_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_valid  (pix_valid),
        .cmd_colour (cmd_colour),
        .cmd_mode   (cmd_mode),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    // Matches the output register stage of the colour unit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= scan_done;
        end
    end

    // Decoder is idle again by the time done rises
    done_while_idle: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(done) |-> !busy
    );

endmodule

/* verification/fillscreen_monitor.sv */
`include "vga_config.svh"

module fillscreen_monitor
    import vga_pkg::*;
    import fill_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  colour_t    colour,
    input  fill_mode_e mode,
    input  logic       done,
    input  coord_x_t   vga_x,
    input  coord_y_t   vga_y,
    input  colour_t    vga_colour,
    input  logic       vga_plot,
    output int         error_count,
    output int         pass_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_PIXELS = `VGA_WIDTH * `VGA_HEIGHT;
    // Cycles between the accepting edge and the first plot cycle
    localparam int PLOT_DELAY   = 2;
    localparam int PRINT_LIMIT  = 20;

    colour_t    cmd_colour;
    fill_mode_e cmd_mode;
    logic       start_prev;
    logic       busy_m;
    logic       pass_active;
    logic       done_m;
    int         wait_cycles;
    int         pixel_idx;
    int         errors;
    int         passes;

    assign error_count = errors;
    assign pass_count  = passes;

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------

    function automatic colour_t model_colour(input fill_mode_e m, input colour_t c,
                                             input int x, input int y);
        case (m)
            FILL_SOLID:   return c;
            FILL_COLUMNS: return colour_t'(x % 8);
            FILL_ROWS:    return colour_t'(y % 8);
            default:      return colour_t'((x + y) % 8);
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            if (errors <= PRINT_LIMIT) begin
                $display("** Error %s: expected 0x%0h, got 0x%0h (pass %0d, pixel %0d)",
                         name, expected, actual, passes + 1, pixel_idx);
            end else if (errors == PRINT_LIMIT + 1) begin
                $display("Too many mismatches, further ones are only counted");
            end
        end
    endtask

    // --------------------------------------------------
    // Cycle checker
    // --------------------------------------------------

    always @(posedge clk or negedge rst_n) begin
        logic accept;
        logic exp_plot;
        logic exp_done;
        int   x;
        int   y;
        if (!rst_n) begin
            start_prev  = 1'b0;
            busy_m      = 1'b0;
            pass_active = 1'b0;
            done_m      = 1'b0;
            wait_cycles = 0;
            pixel_idx   = 0;
        end else begin
            accept   = start && !start_prev && !busy_m;
            exp_plot = pass_active && (wait_cycles == 0);
            exp_done = done_m && !exp_plot;
            compare_value("vga_plot", 32'(exp_plot), 32'(vga_plot));
            compare_value("done", 32'(exp_done), 32'(done));

            if (exp_plot && vga_plot) begin
                x = pixel_idx / `VGA_HEIGHT;
                y = pixel_idx % `VGA_HEIGHT;
                compare_value("vga_x", 32'(x), 32'(vga_x));
                compare_value("vga_y", 32'(y), 32'(vga_y));
                compare_value("vga_colour", 32'(model_colour(cmd_mode, cmd_colour, x, y)),
                              32'(vga_colour));
            end

            if (exp_plot) begin
                done_m = 1'b0;
                pixel_idx++;
                if (pixel_idx == FRAME_PIXELS) begin
                    pass_active = 1'b0;
                    busy_m      = 1'b0;
                    done_m      = 1'b1;
                    passes++;
                end
            end else if (pass_active) begin
                wait_cycles--;
            end

            // New command only while idle
            if (accept) begin
                cmd_colour  = colour;
                cmd_mode    = mode;
                busy_m      = 1'b1;
                pass_active = 1'b1;
                wait_cycles = PLOT_DELAY;
                pixel_idx   = 0;
            end
            start_prev = start;
        end
    end

endmodule

/* verification/tb_fillscreen.sv */
`include "vga_config.svh"

module tb_fillscreen
    import vga_pkg::*;
    import fill_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED         = 5179;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int PASSES       = 8;
    localparam int FRAME_PIXELS = `VGA_WIDTH * `VGA_HEIGHT;
    localparam int MAX_CYCLES   = PASSES * (FRAME_PIXELS + 50) + 1000;

    logic       clk;
    logic       rst_n;
    logic       start;
    colour_t    colour;
    fill_mode_e mode;
    logic       done;
    coord_x_t   vga_x;
    coord_y_t   vga_y;
    colour_t    vga_colour;
    logic       vga_plot;

    int monitor_errors;
    int passes_seen;
    int tb_errors;
    int cycle_count;

    fillscreen dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .mode       (mode),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    fillscreen_monitor mon_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .colour      (colour),
        .mode        (mode),
        .done        (done),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .vga_plot    (vga_plot),
        .error_count (monitor_errors),
        .pass_count  (passes_seen)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------

    task automatic end_run();
        $display("Errors: %0d (monitor %0d, testbench %0d), passes checked: %0d",
                 monitor_errors + tb_errors, monitor_errors, tb_errors, passes_seen);
        if (monitor_errors + tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // Limit covers all passes plus slack for gaps
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles while waiting for done", cycle_count);
            tb_errors++;
            end_run();
        end
    end

    // Old done may still be high right after a start
    task automatic wait_for_done();
        while (done) @(negedge clk);
        while (!done) @(negedge clk);
    endtask

    // --------------------------------------------------
    // One frame fill
    // --------------------------------------------------

    task automatic fill_frame(input fill_mode_e m, input colour_t c,
                              input int hold_cycles, input logic keep_start);
        int noise_at;
        noise_at = $urandom_range(19000, 10);
        @(posedge clk);
        #(DRIVE_DELAY);
        start  = 1'b1;
        colour = c;
        mode   = m;
        repeat (hold_cycles) @(posedge clk);
        #(DRIVE_DELAY);
        start  = keep_start;
        // Inputs wander while the pass runs
        colour = colour_t'($urandom);
        mode   = fill_mode_e'(2'($urandom_range(3, 0)));
        if (!keep_start) begin
            repeat (noise_at) @(posedge clk);
            #(DRIVE_DELAY);
            start  = 1'b1;
            colour = colour_t'($urandom);
            mode   = fill_mode_e'(2'($urandom_range(3, 0)));
            @(posedge clk);
            #(DRIVE_DELAY);
            start = 1'b0;
        end
        wait_for_done();
        if (keep_start) begin
            // Held start must not launch a second pass
            repeat (4) @(posedge clk);
            #(DRIVE_DELAY);
            start = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n  = 1'b0;
        start  = 1'b0;
        colour = '0;
        mode   = FILL_SOLID;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        // Quiet period checks outputs stay low
        repeat (6) @(posedge clk);

        for (int p = 0; p < PASSES; p++) begin
            if (p % 2 == 0) begin
                fill_frame(fill_mode_e'(2'(p / 2)), colour_t'($urandom),
                           $urandom_range(3, 1), 1'b0);
            end else begin
                fill_frame(fill_mode_e'(2'(p / 2)), colour_t'($urandom),
                           1, (p == 5));
            end
        end

        repeat (10) @(negedge clk);
        if (passes_seen != PASSES) begin
            $display("Monitor saw %0d complete passes instead of %0d", passes_seen, PASSES);
            tb_errors++;
        end
        end_run();
    end

endmodule

/* fillscreen.f */
+incdir+common
common/vga_pkg.sv
common/fill_pkg.sv
hw/fill_cmd_decode.sv
hw/fillscreen/pixel_scanner.sv
hw/pixel_colour_unit.sv
hw/fillscreen.sv
verification/fillscreen_monitor.sv
verification/tb_fillscreen.sv

/* Makefile */
# Verilator build and run for the frame-fill engine
#
#   make compile   build the simulator
#   make run       build if needed, run, and check the log
#   make clean     remove build output and log
#
# Any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_fillscreen
FILELIST  ?= fillscreen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Testbench passed
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard common/*.sv common/*.svh hw/*.sv hw/fillscreen/*.sv verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
